// ==== source/cpu_control_params.svh ====
`ifndef CPU_CONTROL_PARAMS_SVH
`define CPU_CONTROL_PARAMS_SVH

// field widths
`define OPCODE_W   6
`define FUNCT_W    6
`define STATE_W    5
`define ALU_CTRL_W 5

// ALU control codes
`define ALU_ADD 5'd0
`define ALU_SUB 5'd1
`define ALU_MUL 5'd2
`define ALU_DIV 5'd3
`define ALU_AND 5'd4
`define ALU_OR  5'd5
`define ALU_NOR 5'd6
`define ALU_SLT 5'd7
`define ALU_SLE 5'd8

// opcodes
`define OP_R     6'b000000
`define OP_ADDI  6'b000001
`define OP_SUBI  6'b000010
`define OP_DIVI  6'b000011
`define OP_MULTI 6'b000100
`define OP_ANDI  6'b000101
`define OP_ORI   6'b000110
`define OP_NORI  6'b000111
`define OP_SLEI  6'b001000
`define OP_SLTI  6'b001001
`define OP_BEQ   6'b001010
`define OP_BNE   6'b001011
`define OP_BLT   6'b001100
`define OP_BGT   6'b001101
`define OP_STI   6'b001110
`define OP_LDI   6'b001111
`define OP_STR   6'b010000
`define OP_LDR   6'b010001
`define OP_HLT   6'b010010
`define OP_IN    6'b010011
`define OP_OUT   6'b010100
`define OP_JMP   6'b010101

`endif

// ==== source/cpu_control_pkg.sv ====
`include "cpu_control_params.svh"

package cpuControlPkg;

	typedef logic [`OPCODE_W-1:0] opcodeT;
	typedef logic [`FUNCT_W-1:0] functT;
	typedef logic [`ALU_CTRL_W-1:0] aluControlT;

	// encodings 16 to 19 unused
	typedef enum logic [`STATE_W-1:0] {
		stFetch        = 5'd0,
		stDecode       = 5'd1,
		stAddrCalc     = 5'd2,
		stMemRead      = 5'd3,
		stLoadWrite    = 5'd4,
		stMemWrite     = 5'd5,
		stRegExec      = 5'd6,
		stRegWriteback = 5'd7,
		stBranchCalc   = 5'd8,
		stJumpCalc     = 5'd9,
		stPcUpdate     = 5'd10,
		stImmExec      = 5'd11,
		stInputWait    = 5'd12,
		stFinish       = 5'd13,
		stHalt         = 5'd14,
		stIoRelease    = 5'd15,
		stOutputWait   = 5'd20
	} stateT;

	typedef enum logic [3:0] {
		clsRegister,
		clsImmediate,
		clsLoad,
		clsStore,
		clsBranch,
		clsJump,
		clsHalt,
		clsInput,
		clsOutput
	} instrClassT;

	typedef struct packed {
		instrClassT instrClass;
		logic       immAddress; // ldi / sti
	} decodedInstrT;

	typedef enum logic [1:0] {
		aluOpFunct = 2'd0,
		aluOpIncr  = 2'd1,
		aluOpAddr  = 2'd3
	} aluOpT;

	typedef struct packed {
		logic writePc;
		logic writeIr;
		logic writeReg;
		logic writeMem;
		logic inputEnable;
		logic outputEnable;
	} controlStrobesT;

	typedef struct packed {
		logic [1:0] pcSel;
		logic       memAddrSel;
		logic       reg1Sel;
		logic       reg2Sel;
		logic       aluASel;
		logic [1:0] aluBSel;
		logic       inSel;
	} muxSelectT;

endpackage

// ==== source/opcode_classifier.sv ====
`timescale 1ns/100ps
`include "cpu_control_params.svh"

module opcodeClassifier (
	input  cpuControlPkg::opcodeT       opcode,
	output cpuControlPkg::decodedInstrT decoded
);
	import cpuControlPkg::*;

	always_comb begin
		decoded.immAddress = 1'b0;
		case (opcode)
			`OP_R: decoded.instrClass = clsRegister;
			`OP_ADDI, `OP_SUBI, `OP_DIVI, `OP_MULTI, `OP_ANDI,
			`OP_ORI, `OP_NORI, `OP_SLEI, `OP_SLTI:
				decoded.instrClass = clsImmediate;
			`OP_LDI: begin
				decoded.instrClass = clsLoad;
				decoded.immAddress = 1'b1;
			end
			`OP_LDR: decoded.instrClass = clsLoad;
			`OP_STI: begin
				decoded.instrClass = clsStore;
				decoded.immAddress = 1'b1;
			end
			`OP_STR: decoded.instrClass = clsStore;
			`OP_BEQ, `OP_BNE, `OP_BLT, `OP_BGT:
				decoded.instrClass = clsBranch;
			`OP_JMP: decoded.instrClass = clsJump;
			`OP_HLT: decoded.instrClass = clsHalt;
			`OP_IN:  decoded.instrClass = clsInput;
			`OP_OUT: decoded.instrClass = clsOutput;
			// unknown opcodes run as register-immediate
			default: decoded.instrClass = clsImmediate;
		endcase
	end

endmodule

// ==== source/control_sequencer.sv ====
`timescale 1ns/100ps

module controlSequencer (
	input  logic                        clk,
	input  logic                        reset,
	input  cpuControlPkg::decodedInstrT decoded,
	input  logic                        enter,
	output cpuControlPkg::stateT        state
);
	import cpuControlPkg::*;

	stateT nextState;

	always_ff @(posedge clk) begin
		if (reset)
			state <= stFetch;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			stFetch: nextState = stDecode;
			stDecode: begin
				case (decoded.instrClass)
					clsOutput:   nextState = stOutputWait;
					clsInput:    nextState = stInputWait;
					clsLoad,
					clsStore:    nextState = stAddrCalc;
					clsRegister: nextState = stRegExec;
					clsBranch:   nextState = stBranchCalc;
					clsJump:     nextState = stJumpCalc;
					clsHalt:     nextState = stHalt;
					default:     nextState = stImmExec;
				endcase
			end
			stAddrCalc: begin
				case (decoded.instrClass)
					clsLoad:  nextState = stMemRead;
					clsStore: nextState = stMemWrite;
					default:  nextState = stFetch;
				endcase
			end
			stMemRead:   nextState = stLoadWrite;
			stLoadWrite: nextState = stFinish;
			stMemWrite:  nextState = stIoRelease; // store ends like an io op
			stRegExec,
			stImmExec:      nextState = stRegWriteback;
			stRegWriteback: nextState = stFetch;
			stBranchCalc:   nextState = stPcUpdate;
			stPcUpdate:     nextState = stFetch;
			stJumpCalc:     nextState = stFinish;
			stFinish:       nextState = stFetch;
			stInputWait,
			stOutputWait: begin
				if (enter)
					nextState = stIoRelease;
			end
			// wait for the operator to let go of enter
			stIoRelease: begin
				if (!enter)
					nextState = stFetch;
			end
			stHalt:  nextState = stHalt;
			default: nextState = stFetch;
		endcase
	end

	// only reset gets the core out of halt
	haltHolds: assert property (@(posedge clk)
		(state == stHalt && !reset) |=> state == stHalt)
		else $error("left stHalt without reset");

	legalState: assert property (@(posedge clk) disable iff (reset)
		state inside {stFetch, stDecode, stAddrCalc, stMemRead, stLoadWrite,
			stMemWrite, stRegExec, stRegWriteback, stBranchCalc, stJumpCalc,
			stPcUpdate, stImmExec, stInputWait, stFinish, stHalt,
			stIoRelease, stOutputWait})
		else $error("illegal state encoding %0h", state);

endmodule

// ==== source/control_word_decoder.sv ====
`timescale 1ns/100ps

module controlWordDecoder (
	input  cpuControlPkg::stateT          state,
	input  cpuControlPkg::decodedInstrT   decoded,
	input  logic                          zero,
	output cpuControlPkg::controlStrobesT strobes,
	output cpuControlPkg::muxSelectT      muxSel,
	output cpuControlPkg::aluOpT          aluOp
);
	import cpuControlPkg::*;

	always_comb begin
		strobes = '0;
		muxSel = '0;
		aluOp = aluOpFunct;
		case (state)
			stFetch: begin
				strobes.writeIr = 1'b1;
				aluOp = aluOpIncr; // pc + 1
				muxSel.aluBSel = 2'b01;
				muxSel.inSel = 1'b1;
			end
			stDecode: begin
				strobes.writePc = (decoded.instrClass != clsHalt);
				strobes.outputEnable = (decoded.instrClass == clsOutput);
				muxSel.aluBSel = 2'b01;
			end
			stAddrCalc: begin
				aluOp = decoded.immAddress ? aluOpAddr : aluOpIncr;
				muxSel.memAddrSel = 1'b1;
				muxSel.aluASel = 1'b1;
				muxSel.aluBSel = 2'b11;
			end
			stMemRead: begin
				muxSel.memAddrSel = 1'b1;
				muxSel.reg2Sel = 1'b1;
			end
			stLoadWrite: begin
				strobes.writeReg = 1'b1;
				muxSel.memAddrSel = 1'b1;
				muxSel.reg2Sel = 1'b1;
			end
			stMemWrite: begin
				strobes.writeMem = 1'b1;
				aluOp = aluOpAddr;
				muxSel.memAddrSel = 1'b1;
				muxSel.aluASel = 1'b1;
			end
			stRegExec: begin
				muxSel.reg1Sel = 1'b1;
				muxSel.aluASel = 1'b1;
			end
			stRegWriteback: begin
				strobes.writeReg = 1'b1;
				muxSel.aluASel = 1'b1;
				// immediate results take B from the sign-extended field
				if (decoded.instrClass == clsRegister) begin
					muxSel.reg1Sel = 1'b1;
				end else begin
					muxSel.aluBSel = 2'b11;
				end
			end
			stBranchCalc: begin
				muxSel.pcSel = 2'b01;
				muxSel.aluASel = 1'b1;
			end
			stJumpCalc: begin
				strobes.writePc = 1'b1;
				aluOp = aluOpAddr;
				muxSel.aluASel = 1'b1;
				muxSel.aluBSel = 2'b11;
			end
			stPcUpdate: begin
				strobes.writePc = zero; // taken only on zero flag
				aluOp = aluOpAddr;
				muxSel.pcSel = 2'b10;
			end
			stImmExec: begin
				muxSel.aluASel = 1'b1;
				muxSel.aluBSel = 2'b11;
			end
			stInputWait: begin
				strobes.writeReg = 1'b1;
				strobes.inputEnable = 1'b1;
				muxSel.inSel = 1'b1;
			end
			stFinish: begin
				strobes.writePc = (decoded.instrClass == clsJump);
				strobes.writeReg = (decoded.instrClass == clsLoad) && decoded.immAddress;
				muxSel.reg2Sel = 1'b1;
			end
			stIoRelease: begin
				strobes.writeReg = !((decoded.instrClass == clsOutput) ||
					((decoded.instrClass == clsStore) && decoded.immAddress));
				muxSel.reg2Sel = 1'b1;
				muxSel.inSel = 1'b1;
			end
			stOutputWait: begin
				strobes.outputEnable = 1'b1;
				muxSel.aluBSel = 2'b01;
			end
			default: ; // stHalt and anything else stay quiet
		endcase
	end

	pcIrExclusive: assert final (!(strobes.writePc && strobes.writeIr))
		else $error("writePc and writeIr both set in state %0d", state);

	regMemExclusive: assert final (!(strobes.writeReg && strobes.writeMem))
		else $error("writeReg and writeMem both set in state %0d", state);

endmodule

// ==== source/alu_control_decoder.sv ====
`timescale 1ns/100ps
`include "cpu_control_params.svh"

module aluControlDecoder (
	input  cpuControlPkg::aluOpT      aluOp,
	input  cpuControlPkg::opcodeT     opcode,
	input  cpuControlPkg::functT      funct,
	output cpuControlPkg::aluControlT aluControl
);
	import cpuControlPkg::*;

	always_comb begin
		aluControl = `ALU_ADD; // incr and addr both add
		if (aluOp == aluOpFunct) begin
			case (opcode)
				`OP_R:     aluControl = aluControlT'(funct[`ALU_CTRL_W-1:0]);
				`OP_ADDI:  aluControl = `ALU_ADD;
				`OP_SUBI:  aluControl = `ALU_SUB;
				`OP_MULTI: aluControl = `ALU_MUL;
				`OP_DIVI:  aluControl = `ALU_DIV;
				`OP_ANDI:  aluControl = `ALU_AND;
				`OP_ORI:   aluControl = `ALU_OR;
				`OP_NORI:  aluControl = `ALU_NOR;
				`OP_SLTI:  aluControl = `ALU_SLT;
				`OP_SLEI:  aluControl = `ALU_SLE;
				// compare for branches
				`OP_BEQ,
				`OP_BNE:   aluControl = `ALU_SUB;
				`OP_BLT:   aluControl = `ALU_SLT;
				`OP_BGT:   aluControl = `ALU_SLE;
				default:   aluControl = `ALU_ADD;
			endcase
		end
	end

endmodule

// ==== source/control_unit_top.sv ====
`timescale 1ns/100ps

module controlUnitTop (
	input  logic                          clk,
	input  logic                          reset,
	input  cpuControlPkg::opcodeT         opcode,
	input  cpuControlPkg::functT          funct,
	input  logic                          zero,
	input  logic                          enter,
	output cpuControlPkg::stateT          state,
	output cpuControlPkg::controlStrobesT strobes,
	output cpuControlPkg::muxSelectT      muxSel,
	output cpuControlPkg::aluControlT     aluControl
);
	import cpuControlPkg::*;

	decodedInstrT decoded;
	aluOpT aluOp;

	opcodeClassifier classifier (
		.opcode (opcode),
		.decoded(decoded)
	);

	controlSequencer sequencer (
		.clk    (clk),
		.reset  (reset),
		.decoded(decoded),
		.enter  (enter),
		.state  (state)
	);

	controlWordDecoder wordDecoder (
		.state  (state),
		.decoded(decoded),
		.zero   (zero),
		.strobes(strobes),
		.muxSel (muxSel),
		.aluOp  (aluOp)
	);

	aluControlDecoder aluDecoder (
		.aluOp     (aluOp),
		.opcode    (opcode),
		.funct     (funct),
		.aluControl(aluControl)
	);

endmodule

// ==== verif/clock_gen.sv ====
`timescale 1ns/100ps

module clockGen #(
	parameter int ResetCycles = 10
) (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk; // 10 ns period
	end

	// drops just after the last reset edge
	initial begin
		reset = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		reset <= 1'b0;
	end

endmodule

// ==== verif/control_unit_tb.sv ====
`timescale 1ns/100ps

module controlUnitTb;
	import cpuControlPkg::*;

	localparam int MaxFileLines = 1000;
	localparam int ResetTimeout = 100;

	typedef struct packed {
		opcodeT         opcode;
		functT          funct;
		logic           zero;
		logic           enter;
		logic           reset;
		stateT          state;
		controlStrobesT strobes;
		muxSelectT      muxSel;
		aluControlT     aluControl;
	} goldenLineT;

	logic clk;
	logic genReset;
	logic lineReset; // reset pulses requested by the golden file
	logic reset;
	opcodeT opcode;
	functT funct;
	logic zero;
	logic enter;
	stateT state;
	controlStrobesT strobes;
	muxSelectT muxSel;
	aluControlT aluControl;

	goldenLineT goldenLines[$];
	int fileLineNums[$];

	assign reset = genReset | lineReset;

	clockGen clockSource (
		.clk  (clk),
		.reset(genReset)
	);

	controlUnitTop dut (
		.clk       (clk),
		.reset     (reset),
		.opcode    (opcode),
		.funct     (funct),
		.zero      (zero),
		.enter     (enter),
		.state     (state),
		.strobes   (strobes),
		.muxSel    (muxSel),
		.aluControl(aluControl)
	);

	task automatic failRun(input string reason);
		$display("TEST RESULT: FAIL");
		$fatal(1, "%s", reason);
	endtask

	task automatic checkState(input stateT actual, input stateT expected, input int lineNo);
		if (actual !== expected) begin
			$display("[FAIL] line %0d state: got %h, expected %h", lineNo, actual, expected);
			failRun("state mismatch");
		end
	endtask

	task automatic checkStrobes(input controlStrobesT actual, input controlStrobesT expected,
		input int lineNo);
		if (actual !== expected) begin
			$display("[FAIL] line %0d strobes: got %h, expected %h", lineNo, actual, expected);
			failRun("strobes mismatch");
		end
	endtask

	task automatic checkMuxSel(input muxSelectT actual, input muxSelectT expected,
		input int lineNo);
		if (actual !== expected) begin
			$display("[FAIL] line %0d muxSel: got %h, expected %h", lineNo, actual, expected);
			failRun("muxSel mismatch");
		end
	endtask

	task automatic checkAluControl(input aluControlT actual, input aluControlT expected,
		input int lineNo);
		if (actual !== expected) begin
			$display("[FAIL] line %0d aluControl: got %h, expected %h", lineNo, actual,
				expected);
			failRun("aluControl mismatch");
		end
	endtask

	task automatic readGolden();
		int fd;
		int count;
		int lineNo;
		string text;
		logic [31:0] field [9];
		goldenLineT entry;
		fd = $fopen("verif/control_unit_golden.txt", "r");
		if (fd == 0)
			failRun("could not open verif/control_unit_golden.txt");
		lineNo = 0;
		while (!$feof(fd) && lineNo < MaxFileLines) begin
			lineNo++;
			if ($fgets(text, fd) == 0)
				break;
			if (text.len() == 0 || text.substr(0, 0) == "#")
				continue; // comment or empty
			count = $sscanf(text, "%h %h %h %h %h %h %h %h %h", field[0], field[1],
				field[2], field[3], field[4], field[5], field[6], field[7], field[8]);
			if (count == 9) begin
				entry.opcode = field[0][5:0];
				entry.funct = field[1][5:0];
				entry.zero = field[2][0];
				entry.enter = field[3][0];
				entry.reset = field[4][0];
				entry.state = stateT'(field[5][4:0]);
				entry.strobes = field[6][5:0];
				entry.muxSel = field[7][8:0];
				entry.aluControl = field[8][4:0];
				goldenLines.push_back(entry);
				fileLineNums.push_back(lineNo);
			end else if (count > 0) begin
				failRun($sformatf("golden file line %0d has the wrong number of columns",
					lineNo));
			end
		end
		$fclose(fd);
		if (goldenLines.size() == 0)
			failRun("the golden file holds no data lines");
	endtask

	initial begin
		int waitCycles;
		opcode = '0;
		funct = '0;
		zero = 1'b0;
		enter = 1'b0;
		lineReset = 1'b0;
		readGolden();

		waitCycles = 0;
		do begin
			@(negedge clk);
			waitCycles++;
			if (waitCycles > ResetTimeout)
				failRun("reset was never released");
		end while (genReset);

		// apply one golden line per cycle and check it at the falling edge
		foreach (goldenLines[i]) begin
			@(posedge clk);
			opcode <= goldenLines[i].opcode;
			funct <= goldenLines[i].funct;
			zero <= goldenLines[i].zero;
			enter <= goldenLines[i].enter;
			lineReset <= goldenLines[i].reset;
			@(negedge clk);
			checkState(state, goldenLines[i].state, fileLineNums[i]);
			checkStrobes(strobes, goldenLines[i].strobes, fileLineNums[i]);
			checkMuxSel(muxSel, goldenLines[i].muxSel, fileLineNums[i]);
			checkAluControl(aluControl, goldenLines[i].aluControl, fileLineNums[i]);
		end

		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule

// ==== verif/control_unit_golden.txt ====
# columns (hex): opcode funct zero enter reset | state strobes muxSel aluControl
# one line per clock; a reset or enter on a line acts on the next line's state
# reset release, then a reset pulse that brings back stFetch
00 00 0 0 1  01 20 002 00
# R-type, funct 2a keeps its low five bits
00 2a 0 0 0  00 10 003 00
00 2a 0 0 0  01 20 002 0a
00 2a 0 0 0  06 00 028 0a
00 2a 0 0 0  07 08 028 0a
# addi
01 00 0 0 0  00 10 003 00
01 00 0 0 0  01 20 002 00
01 00 0 0 0  0b 00 00e 00
01 00 0 0 0  07 08 00e 00
# subi
02 00 0 0 0  00 10 003 00
02 00 0 0 0  01 20 002 01
02 00 0 0 0  0b 00 00e 01
02 00 0 0 0  07 08 00e 01
# multi
04 00 0 0 0  00 10 003 00
04 00 0 0 0  01 20 002 02
04 00 0 0 0  0b 00 00e 02
04 00 0 0 0  07 08 00e 02
# divi
03 00 0 0 0  00 10 003 00
03 00 0 0 0  01 20 002 03
03 00 0 0 0  0b 00 00e 03
03 00 0 0 0  07 08 00e 03
# andi
05 00 0 0 0  00 10 003 00
05 00 0 0 0  01 20 002 04
05 00 0 0 0  0b 00 00e 04
05 00 0 0 0  07 08 00e 04
# ori
06 00 0 0 0  00 10 003 00
06 00 0 0 0  01 20 002 05
06 00 0 0 0  0b 00 00e 05
06 00 0 0 0  07 08 00e 05
# nori
07 00 0 0 0  00 10 003 00
07 00 0 0 0  01 20 002 06
07 00 0 0 0  0b 00 00e 06
07 00 0 0 0  07 08 00e 06
# slti
09 00 0 0 0  00 10 003 00
09 00 0 0 0  01 20 002 07
09 00 0 0 0  0b 00 00e 07
09 00 0 0 0  07 08 00e 07
# slei
08 00 0 0 0  00 10 003 00
08 00 0 0 0  01 20 002 08
08 00 0 0 0  0b 00 00e 08
08 00 0 0 0  07 08 00e 08
# unknown opcode runs as immediate with add
3f 00 0 0 0  00 10 003 00
3f 00 0 0 0  01 20 002 00
3f 00 0 0 0  0b 00 00e 00
3f 00 0 0 0  07 08 00e 00
# ldi, ldr
0f 00 0 0 0  00 10 003 00
0f 00 0 0 0  01 20 002 00
0f 00 0 0 0  02 00 04e 00
0f 00 0 0 0  03 00 050 00
0f 00 0 0 0  04 08 050 00
0f 00 0 0 0  0d 08 010 00
11 00 0 0 0  00 10 003 00
11 00 0 0 0  01 20 002 00
11 00 0 0 0  02 00 04e 00
11 00 0 0 0  03 00 050 00
11 00 0 0 0  04 08 050 00
11 00 0 0 0  0d 00 010 00
# sti, then str held one extra cycle by enter
0e 00 0 0 0  00 10 003 00
0e 00 0 0 0  01 20 002 00
0e 00 0 0 0  02 00 04e 00
0e 00 0 0 0  05 04 048 00
0e 00 0 0 0  0f 00 011 00
10 00 0 0 0  00 10 003 00
10 00 0 0 0  01 20 002 00
10 00 0 0 0  02 00 04e 00
10 00 0 0 0  05 04 048 00
10 00 0 1 0  0f 08 011 00
10 00 0 0 0  0f 08 011 00
# branches, zero alternates
0a 00 1 0 0  00 10 003 00
0a 00 1 0 0  01 20 002 01
0a 00 1 0 0  08 00 088 01
0a 00 1 0 0  0a 20 100 00
0b 00 0 0 0  00 10 003 00
0b 00 0 0 0  01 20 002 01
0b 00 0 0 0  08 00 088 01
0b 00 0 0 0  0a 00 100 00
0c 00 1 0 0  00 10 003 00
0c 00 1 0 0  01 20 002 07
0c 00 1 0 0  08 00 088 07
0c 00 1 0 0  0a 20 100 00
0d 00 0 0 0  00 10 003 00
0d 00 0 0 0  01 20 002 08
0d 00 0 0 0  08 00 088 08
0d 00 0 0 0  0a 00 100 00
# jmp
15 00 0 0 0  00 10 003 00
15 00 0 0 0  01 20 002 00
15 00 0 0 0  09 20 00e 00
15 00 0 0 0  0d 20 010 00
# in
13 00 0 0 0  00 10 003 00
13 00 0 0 0  01 20 002 00
13 00 0 0 0  0c 0a 001 00
13 00 0 0 0  0c 0a 001 00
13 00 0 1 0  0c 0a 001 00
13 00 0 1 0  0f 08 011 00
13 00 0 0 0  0f 08 011 00
# out
14 00 0 0 0  00 10 003 00
14 00 0 0 0  01 21 002 00
14 00 0 0 0  14 01 002 00
14 00 0 0 0  14 01 002 00
14 00 0 1 0  14 01 002 00
14 00 0 1 0  0f 00 011 00
14 00 0 0 0  0f 00 011 00
# hlt, then a reset
12 00 0 0 0  00 10 003 00
12 00 0 0 0  01 00 002 00
12 00 0 0 0  0e 00 000 00
12 00 0 0 0  0e 00 000 00
12 00 0 1 0  0e 00 000 00
12 00 1 0 0  0e 00 000 00
12 00 0 0 1  0e 00 000 00
00 00 0 0 0  00 10 003 00
00 00 0 0 0  01 20 002 00

// ==== build.f ====
+incdir+source
source/cpu_control_pkg.sv
source/opcode_classifier.sv
source/control_sequencer.sv
source/control_word_decoder.sv
source/alu_control_decoder.sv
source/control_unit_top.sv
verif/clock_gen.sv
verif/control_unit_tb.sv
